// File: rvv_mask_dim_pkg.sv
package rvv_mask_dim_pkg;

  // vector register geometry
  localparam int vlen = 128;
  localparam int rob_depth_width = 4;
  localparam int vl_width = 8;

  // vcpop walks the register one slice per cycle
  localparam int cpop_chunk = 32;
  localparam int cpop_steps = vlen / cpop_chunk;
  localparam int cpop_idx_width = $clog2(cpop_steps);

  // wide enough to hold a count of vlen
  localparam int cpop_sum_width = $clog2(vlen) + 1;

  // one vector register
  typedef logic [vlen-1:0] vreg_t;

  // reorder buffer entry
  typedef logic [rob_depth_width-1:0] rob_tag_t;

  // vector length and start element
  typedef logic [vl_width-1:0] vl_t;
  typedef logic [vl_width-1:0] vstart_t;

endpackage

// File: rvv_mask_op_pkg.sv
package rvv_mask_op_pkg;

  // instruction fields
  typedef logic [2:0] funct3_t;
  typedef logic [5:0] funct6_t;
  typedef logic [4:0] vs1_field_t;

  localparam funct3_t opmvv = 3'd2;

  // mask-logical group, funct6 0x18 to 0x1f
  localparam funct6_t funct6_vmandn = 6'h18;
  localparam funct6_t funct6_vmand  = 6'h19;
  localparam funct6_t funct6_vmor   = 6'h1a;
  localparam funct6_t funct6_vmxor  = 6'h1b;
  localparam funct6_t funct6_vmorn  = 6'h1c;
  localparam funct6_t funct6_vmnand = 6'h1d;
  localparam funct6_t funct6_vmnor  = 6'h1e;
  localparam funct6_t funct6_vmxnor = 6'h1f;

  // unary groups, sub-op selected by the vs1 field
  localparam funct6_t funct6_vwxunary0 = 6'h10;
  localparam funct6_t funct6_vmunary0  = 6'h14;

  localparam vs1_field_t vs1_vcpop  = 5'h10;
  localparam vs1_field_t vs1_vfirst = 5'h11;
  localparam vs1_field_t vs1_vmsbf  = 5'h01;
  localparam vs1_field_t vs1_vmsof  = 5'h02;
  localparam vs1_field_t vs1_vmsif  = 5'h03;

  // internal operation after decode
  typedef enum logic [3:0] {
    op_none, op_andn, op_and, op_or, op_xor, op_orn, op_nand, op_nor, op_xnor,
    op_msbf, op_msif, op_msof, op_first, op_cpop
  } mask_op_e;

endpackage

// File: mask_uop_if.sv
interface mask_uop_if
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
();

  logic     valid;
  logic     ready;
  mask_op_e op;
  rob_tag_t rob_entry;

  // operands, already masked by the issue stage where needed
  vreg_t    src2;
  vreg_t    src1;
  vreg_t    vd;
  vreg_t    v0;
  logic     vm;
  vstart_t  vstart;

  modport issue (
    output valid, op, rob_entry, src2, src1, vd, v0, vm, vstart,
    input  ready
  );

  modport unit (
    input  valid, op, rob_entry, src2, src1, vd, v0, vm, vstart,
    output ready
  );

endinterface

// File: mask_result_if.sv
interface mask_result_if
  import rvv_mask_dim_pkg::*;
();

  logic     valid;
  logic     ready;
  rob_tag_t rob_entry;
  vreg_t    data;

  modport unit (
    output valid, rob_entry, data,
    input  ready
  );

  modport arb (
    input  valid, rob_entry, data,
    output ready
  );

endinterface

// File: rvv_mask_issue.sv
module rvv_mask_issue
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
(
  input  logic       uop_valid,
  input  funct3_t    uop_funct3,
  input  funct6_t    uop_funct6,
  input  vs1_field_t uop_vs1,
  input  rob_tag_t   uop_rob_entry,
  input  vl_t        uop_vl,
  input  vstart_t    uop_vstart,
  input  logic       uop_vm,
  input  vreg_t      vs1_data,
  input  vreg_t      vs2_data,
  input  vreg_t      v0_data,
  input  vreg_t      vd_data,
  output logic       uop_ready,
  mask_uop_if.issue  logic_uop,
  mask_uop_if.issue  scan_uop
);

  mask_op_e op;
  logic     is_logic;
  logic     is_scan;
  vreg_t    tail_mask;
  vreg_t    v0_gate;
  vreg_t    scan_src2;

  always_comb begin
    op = op_none;
    if (uop_funct3 == opmvv) begin
      case (uop_funct6)
        // mask-logical forms exist only unmasked
        funct6_vmandn: op = uop_vm ? op_andn : op_none;
        funct6_vmand:  op = uop_vm ? op_and  : op_none;
        funct6_vmor:   op = uop_vm ? op_or   : op_none;
        funct6_vmxor:  op = uop_vm ? op_xor  : op_none;
        funct6_vmorn:  op = uop_vm ? op_orn  : op_none;
        funct6_vmnand: op = uop_vm ? op_nand : op_none;
        funct6_vmnor:  op = uop_vm ? op_nor  : op_none;
        funct6_vmxnor: op = uop_vm ? op_xnor : op_none;
        funct6_vwxunary0: begin
          if (uop_vs1 == vs1_vcpop) begin
            op = op_cpop;
          end else if (uop_vs1 == vs1_vfirst) begin
            op = op_first;
          end
        end
        funct6_vmunary0: begin
          if (uop_vs1 == vs1_vmsbf) begin
            op = op_msbf;
          end else if (uop_vs1 == vs1_vmsif) begin
            op = op_msif;
          end else if (uop_vs1 == vs1_vmsof) begin
            op = op_msof;
          end
        end
        default: op = op_none;
      endcase
    end
  end

  assign is_logic = op inside {op_andn, op_and, op_or, op_xor, op_orn, op_nand, op_nor, op_xnor};
  assign is_scan  = op inside {op_msbf, op_msif, op_msof, op_first, op_cpop};

  // elements at or above vl are tail
  always_comb begin
    for (int i = 0; i < vlen; i++) begin
      tail_mask[i] = i < int'(uop_vl);
    end
  end

  assign v0_gate = uop_vm ? '1 : v0_data;

  // scalar results drop the tail, set-first keeps it
  assign scan_src2 = (op inside {op_first, op_cpop}) ? (vs2_data & tail_mask & v0_gate)
                                                     : (vs2_data & v0_gate);

  assign logic_uop.valid     = uop_valid && is_logic;
  assign logic_uop.op        = op;
  assign logic_uop.rob_entry = uop_rob_entry;
  assign logic_uop.src2      = vs2_data;
  assign logic_uop.src1      = vs1_data;
  assign logic_uop.vd        = vd_data;
  assign logic_uop.v0        = v0_data;
  assign logic_uop.vm        = uop_vm;
  assign logic_uop.vstart    = uop_vstart;

  assign scan_uop.valid      = uop_valid && is_scan;
  assign scan_uop.op         = op;
  assign scan_uop.rob_entry  = uop_rob_entry;
  assign scan_uop.src2       = scan_src2;
  assign scan_uop.src1       = vs1_data;
  assign scan_uop.vd         = vd_data;
  assign scan_uop.v0         = v0_data;
  assign scan_uop.vm         = uop_vm;
  assign scan_uop.vstart     = uop_vstart;

  // unsupported ops are swallowed
  assign uop_ready = is_logic ? logic_uop.ready :
                     is_scan  ? scan_uop.ready  : 1'b1;

endmodule

// File: rvv_mask_logic_unit.sv
module rvv_mask_logic_unit
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  mask_uop_if.unit    uop,
  mask_result_if.unit res
);

  vreg_t    bitwise;
  vreg_t    merged;
  logic     take;
  logic     res_valid_q;
  rob_tag_t res_rob_q;
  vreg_t    res_data_q;

  always_comb begin
    case (uop.op)
      op_andn: bitwise = uop.src2 & ~uop.src1;
      op_and:  bitwise = uop.src2 & uop.src1;
      op_or:   bitwise = uop.src2 | uop.src1;
      op_xor:  bitwise = uop.src2 ^ uop.src1;
      op_orn:  bitwise = uop.src2 | ~uop.src1;
      op_nand: bitwise = ~(uop.src2 & uop.src1);
      op_nor:  bitwise = ~(uop.src2 | uop.src1);
      op_xnor: bitwise = ~(uop.src2 ^ uop.src1);
      default: bitwise = '0;
    endcase
  end

  // prestart bits keep the old destination
  always_comb begin
    for (int i = 0; i < vlen; i++) begin
      merged[i] = (i < int'(uop.vstart)) ? uop.vd[i] : bitwise[i];
    end
  end

  assign uop.ready = !res_valid_q || res.ready;
  assign take      = uop.valid && uop.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (res.ready) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_rob_q  <= uop.rob_entry;
      res_data_q <= merged;
    end
  end

  assign res.valid     = res_valid_q;
  assign res.rob_entry = res_rob_q;
  assign res.data      = res_data_q;

endmodule

// File: rvv_mask_scan_unit.sv
module rvv_mask_scan_unit
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  mask_uop_if.unit    uop,
  mask_result_if.unit res
);

  typedef enum logic [1:0] {idle, count, done} scan_state_e;

  scan_state_e                state_q;
  logic                       take;
  logic                       last;
  vreg_t                      minus_one;
  vreg_t                      set_first;
  vreg_t                      set_merged;
  vreg_t                      first_data;
  vreg_t                      direct_data;
  logic [cpop_chunk-1:0]      chunk_bits;
  logic [cpop_sum_width-1:0]  acc_next;
  logic [cpop_idx_width-1:0]  cpop_idx_q;
  logic [cpop_sum_width-1:0]  cpop_acc_q;
  vreg_t                      cpop_src_q;
  rob_tag_t                   res_rob_q;
  vreg_t                      res_data_q;

  function automatic logic [cpop_sum_width-1:0] ones_in(logic [cpop_chunk-1:0] bits);
    logic [cpop_sum_width-1:0] total;
    total = '0;
    for (int i = 0; i < cpop_chunk; i++) begin
      total = total + cpop_sum_width'(bits[i]);
    end
    return total;
  endfunction

  // borrow chain marks everything up to the lowest one
  assign minus_one = uop.src2 - vreg_t'(1);

  always_comb begin
    case (uop.op)
      op_msbf: set_first = minus_one & ~uop.src2;
      op_msif: set_first = minus_one ^ uop.src2;
      default: set_first = uop.src2 & ~minus_one;
    endcase
  end

  assign set_merged = uop.vm ? set_first : ((set_first & uop.v0) | (uop.vd & ~uop.v0));

  // lowest set index, all ones if empty
  always_comb begin
    first_data = '1;
    for (int i = vlen - 1; i >= 0; i--) begin
      if (uop.src2[i]) begin
        first_data = vreg_t'(i);
      end
    end
  end

  assign direct_data = (uop.op == op_first) ? first_data : set_merged;

  // first slice is counted on the accept cycle
  assign chunk_bits = (state_q == idle) ? uop.src2[cpop_chunk-1:0]
                                        : cpop_src_q[cpop_idx_q*cpop_chunk +: cpop_chunk];
  assign acc_next   = ((state_q == idle) ? '0 : cpop_acc_q) + ones_in(chunk_bits);
  assign last       = cpop_idx_q == cpop_idx_width'(cpop_steps - 1);

  assign uop.ready = state_q == idle;
  assign take      = uop.valid && uop.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= idle;
      cpop_idx_q <= '0;
    end else begin
      case (state_q)
        idle: begin
          if (take) begin
            state_q    <= (uop.op == op_cpop) ? count : done;
            cpop_idx_q <= cpop_idx_width'(1);
          end
        end
        count: begin
          cpop_idx_q <= cpop_idx_q + 1'b1;
          if (last) begin
            state_q <= done;
          end
        end
        done: begin
          if (res.ready) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_rob_q  <= uop.rob_entry;
      cpop_src_q <= uop.src2;
      cpop_acc_q <= acc_next;
      res_data_q <= direct_data;
    end else if (state_q == count) begin
      cpop_acc_q <= acc_next;
      if (last) begin
        res_data_q <= vreg_t'(acc_next);
      end
    end
  end

  assign res.valid     = state_q == done;
  assign res.rob_entry = res_rob_q;
  assign res.data      = res_data_q;

endmodule

// File: rvv_mask_result_arb.sv
module rvv_mask_result_arb
  import rvv_mask_dim_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  mask_result_if.arb logic_res,
  mask_result_if.arb scan_res,
  input  logic       result_ready,
  output logic       result_valid,
  output rob_tag_t   result_rob_entry,
  output vreg_t      result_data
);

  // grant 0 is the logic unit, 1 the scan unit
  logic grant;
  logic rr_q;
  logic lock_q;
  logic lock_sel_q;

  always_comb begin
    if (lock_q) begin
      grant = lock_sel_q;
    end else if (logic_res.valid && scan_res.valid) begin
      grant = rr_q;
    end else begin
      grant = !logic_res.valid;
    end
  end

  assign result_valid     = grant ? scan_res.valid     : logic_res.valid;
  assign result_rob_entry = grant ? scan_res.rob_entry : logic_res.rob_entry;
  assign result_data      = grant ? scan_res.data      : logic_res.data;

  assign logic_res.ready = result_ready && !grant;
  assign scan_res.ready  = result_ready && grant;

  always_ff @(posedge clk) begin
    if (reset) begin
      rr_q       <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      // hold the offer steady while the rob stalls
      lock_q     <= result_valid && !result_ready;
      lock_sel_q <= grant;
      if (result_valid && result_ready) begin
        rr_q <= !grant;
      end
    end
  end

endmodule

// File: rvv_mask_top.sv
module rvv_mask_top
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       uop_valid,
  input  funct3_t    uop_funct3,
  input  funct6_t    uop_funct6,
  input  vs1_field_t uop_vs1,
  input  rob_tag_t   uop_rob_entry,
  input  vl_t        uop_vl,
  input  vstart_t    uop_vstart,
  input  logic       uop_vm,
  input  vreg_t      vs1_data,
  input  vreg_t      vs2_data,
  input  vreg_t      v0_data,
  input  vreg_t      vd_data,
  input  logic       result_ready,
  output logic       uop_ready,
  output logic       result_valid,
  output rob_tag_t   result_rob_entry,
  output vreg_t      result_data
);

  mask_uop_if    logic_uop_bus ();
  mask_uop_if    scan_uop_bus ();
  mask_result_if logic_res_bus ();
  mask_result_if scan_res_bus ();

  rvv_mask_issue u_issue (
    .uop_valid     (uop_valid),
    .uop_funct3    (uop_funct3),
    .uop_funct6    (uop_funct6),
    .uop_vs1       (uop_vs1),
    .uop_rob_entry (uop_rob_entry),
    .uop_vl        (uop_vl),
    .uop_vstart    (uop_vstart),
    .uop_vm        (uop_vm),
    .vs1_data      (vs1_data),
    .vs2_data      (vs2_data),
    .v0_data       (v0_data),
    .vd_data       (vd_data),
    .uop_ready     (uop_ready),
    .logic_uop     (logic_uop_bus.issue),
    .scan_uop      (scan_uop_bus.issue)
  );

  rvv_mask_logic_unit u_logic (
    .clk   (clk),
    .reset (reset),
    .uop   (logic_uop_bus.unit),
    .res   (logic_res_bus.unit)
  );

  rvv_mask_scan_unit u_scan (
    .clk   (clk),
    .reset (reset),
    .uop   (scan_uop_bus.unit),
    .res   (scan_res_bus.unit)
  );

  rvv_mask_result_arb u_arb (
    .clk              (clk),
    .reset            (reset),
    .logic_res        (logic_res_bus.arb),
    .scan_res         (scan_res_bus.arb),
    .result_ready     (result_ready),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

// File: tb_rvv_mask_model.svh
// expected results, worked out bit by bit from the instruction rules

function automatic int lowest_set(vreg_t v);
  int idx;
  idx = vlen;
  for (int i = vlen - 1; i >= 0; i--) begin
    if (v[i]) begin
      idx = i;
    end
  end
  return idx;
endfunction

function automatic logic logic_bit(funct6_t f6, logic x, logic y);
  case (f6)
    funct6_vmandn: return x & ~y;
    funct6_vmand:  return x & y;
    funct6_vmor:   return x | y;
    funct6_vmxor:  return x ^ y;
    funct6_vmorn:  return x | ~y;
    funct6_vmnand: return ~(x & y);
    funct6_vmnor:  return ~(x | y);
    default:       return ~(x ^ y);
  endcase
endfunction

function automatic vreg_t expect_uop(funct3_t f3, funct6_t f6, vs1_field_t f1, logic vm,
                                     vl_t vl, vstart_t vstart, vreg_t a2, vreg_t a1,
                                     vreg_t m0, vreg_t d, output logic supported);
  vreg_t r;
  vreg_t src;
  int first;
  int ones;
  r = '0;
  ones = 0;
  supported = 1'b0;
  src = vm ? a2 : (a2 & m0);
  if (f3 == opmvv && f6 >= funct6_vmandn && f6 <= funct6_vmxnor && vm) begin
    supported = 1'b1;
    for (int i = 0; i < vlen; i++) begin
      r[i] = (i < int'(vstart)) ? d[i] : logic_bit(f6, a2[i], a1[i]);
    end
  end else if (f3 == opmvv && f6 == funct6_vmunary0 &&
               f1 inside {vs1_vmsbf, vs1_vmsif, vs1_vmsof}) begin
    supported = 1'b1;
    first = lowest_set(src);
    for (int i = 0; i < vlen; i++) begin
      case (f1)
        vs1_vmsbf: r[i] = i < first;
        vs1_vmsif: r[i] = i <= first;
        default:   r[i] = i == first;
      endcase
      // inactive elements keep vd
      if (!vm && !m0[i]) begin
        r[i] = d[i];
      end
    end
  end else if (f3 == opmvv && f6 == funct6_vwxunary0 && f1 inside {vs1_vfirst, vs1_vcpop}) begin
    supported = 1'b1;
    for (int i = 0; i < vlen; i++) begin
      if (i >= int'(vl)) begin
        src[i] = 1'b0;
      end
      ones += int'(src[i]);
    end
    first = lowest_set(src);
    if (f1 == vs1_vcpop) begin
      r = vreg_t'(ones);
    end else begin
      r = (first == vlen) ? '1 : vreg_t'(first);
    end
  end
  return r;
endfunction

// File: tb_rvv_mask.sv
module tb_rvv_mask
  import rvv_mask_dim_pkg::*;
  import rvv_mask_op_pkg::*;
();

  localparam int rob_entries = 2 ** rob_depth_width;
  localparam int reset_cycles = 8;
  localparam int total_uops = 94;
  localparam int cycle_limit = 40 * total_uops + reset_cycles;
  // at most one result per unit is outstanding
  localparam int drain_limit = 80;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       uop_valid = 1'b0;
  funct3_t    uop_funct3 = '0;
  funct6_t    uop_funct6 = '0;
  vs1_field_t uop_vs1 = '0;
  rob_tag_t   uop_rob_entry = '0;
  vl_t        uop_vl = '0;
  vstart_t    uop_vstart = '0;
  logic       uop_vm = 1'b0;
  vreg_t      vs1_data = '0;
  vreg_t      vs2_data = '0;
  vreg_t      v0_data = '0;
  vreg_t      vd_data = '0;
  logic       result_ready = 1'b0;
  logic       uop_ready;
  logic       result_valid;
  rob_tag_t   result_rob_entry;
  vreg_t      result_data;

  logic     stall_mode = 1'b0;
  rob_tag_t next_tag = '0;
  int       issued_cnt [rob_entries];
  int       done_cnt [rob_entries];
  vreg_t    exp_data [rob_entries];
  int       total_issued = 0;
  int       total_done = 0;
  int       checks = 0;
  int       mon_errors = 0;
  int       stim_errors = 0;
  int       cycles = 0;
  int       tests_run = 0;
  int       mark_checks = 0;
  int       mark_errors = 0;
  logic     held = 1'b0;
  rob_tag_t held_tag;
  vreg_t    held_data;

  `include "tb_rvv_mask_model.svh"

  rvv_mask_top u_dut (.*);

  always #10 clk = ~clk;

  // rob side stalls at random when enabled
  always @(posedge clk) begin
    if (stall_mode) begin
      result_ready <= ($urandom_range(0, 3) == 0);
    end else begin
      result_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // scoreboard sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (held) begin
        assert (result_valid) else begin
          $display("result_valid dropped before the stalled result was taken");
          mon_errors++;
        end
        assert (result_rob_entry == held_tag) else begin
          $display("mismatch result_rob_entry under stall: got %h expected %h",
                   result_rob_entry, held_tag);
          mon_errors++;
        end
        assert (result_data == held_data) else begin
          $display("mismatch result_data under stall: got %h expected %h",
                   result_data, held_data);
          mon_errors++;
        end
      end
      if (result_valid && result_ready) begin
        checks++;
        assert (issued_cnt[result_rob_entry] > done_cnt[result_rob_entry]) else begin
          $display("result for tag %0d arrived with no micro-op outstanding", result_rob_entry);
          mon_errors++;
        end
        if (issued_cnt[result_rob_entry] > done_cnt[result_rob_entry]) begin
          assert (result_data == exp_data[result_rob_entry]) else begin
            $display("mismatch result_data tag %h: got %h expected %h",
                     result_rob_entry, result_data, exp_data[result_rob_entry]);
            mon_errors++;
          end
          done_cnt[result_rob_entry]++;
          total_done++;
        end
      end
      held = result_valid && !result_ready;
      held_tag = result_rob_entry;
      held_data = result_data;
    end
  end

  function automatic vreg_t rand_vreg();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // low bits cleared so the first set bit moves around
  function automatic vreg_t sparse_vreg();
    return rand_vreg() << $urandom_range(0, vlen - 1);
  endfunction

  task automatic send_uop(input funct3_t f3, input funct6_t f6, input vs1_field_t f1,
                          input logic vm, input vl_t vl, input vstart_t vs,
                          input vreg_t a2, input vreg_t a1, input vreg_t m0, input vreg_t d);
    logic  supported;
    vreg_t expected;
    expected = expect_uop(f3, f6, f1, vm, vl, vs, a2, a1, m0, d, supported);
    assert (issued_cnt[next_tag] == done_cnt[next_tag]) else begin
      $display("tag %0d reused while its result was still outstanding", next_tag);
      stim_errors++;
    end
    @(posedge clk);
    uop_valid     <= 1'b1;
    uop_funct3    <= f3;
    uop_funct6    <= f6;
    uop_vs1       <= f1;
    uop_vm        <= vm;
    uop_vl        <= vl;
    uop_vstart    <= vs;
    uop_rob_entry <= next_tag;
    vs2_data      <= a2;
    vs1_data      <= a1;
    v0_data       <= m0;
    vd_data       <= d;
    @(negedge clk);
    while (!uop_ready) @(negedge clk);
    // taken on the coming edge
    if (supported) begin
      exp_data[next_tag] = expected;
      issued_cnt[next_tag]++;
      total_issued++;
    end
    next_tag = rob_tag_t'(next_tag + 1);
  endtask

  task automatic send_random(input funct3_t f3, input funct6_t f6, input vs1_field_t f1,
                             input logic vm);
    send_uop(f3, f6, f1, vm, vl_t'($urandom_range(0, vlen)),
             vstart_t'($urandom_range(0, vlen - 1)),
             sparse_vreg(), rand_vreg(), rand_vreg(), rand_vreg());
  endtask

  task automatic finish_test(input string name);
    int wait_cycles;
    @(posedge clk);
    uop_valid <= 1'b0;
    wait_cycles = 0;
    while (total_done != total_issued && wait_cycles < drain_limit) begin
      @(negedge clk);
      wait_cycles++;
    end
    $display("test %-13s %0d results checked, %0d errors", name, checks - mark_checks,
             stim_errors + mon_errors - mark_errors);
    mark_checks = checks;
    mark_errors = stim_errors + mon_errors;
    tests_run++;
  endtask

  initial begin
    vl_t vl;
    void'($urandom(18));
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    for (int f = 0; f < 8; f++) begin
      for (int n = 0; n < 4; n++) begin
        send_random(opmvv, funct6_t'(int'(funct6_vmandn) + f), '0, 1'b1);
      end
    end
    finish_test("logical");

    // vmsbf then vmsof then vmsif with a zero source on the last pass
    for (int s = 1; s <= 3; s++) begin
      for (int m = 0; m < 2; m++) begin
        for (int n = 0; n < 3; n++) begin
          send_uop(opmvv, funct6_vmunary0, vs1_field_t'(s), logic'(m == 0), vl_t'(vlen), '0,
                   (n == 2) ? '0 : sparse_vreg(), rand_vreg(), rand_vreg(), rand_vreg());
        end
      end
    end
    finish_test("set-first");

    // vl of zero leaves nothing to find
    for (int s = 0; s < 2; s++) begin
      for (int m = 0; m < 2; m++) begin
        for (int n = 0; n < 3; n++) begin
          vl = (n == 0) ? vl_t'($urandom_range(1, vlen)) : (n == 1) ? vl_t'(vlen) : '0;
          send_uop(opmvv, funct6_vwxunary0, (s == 0) ? vs1_vcpop : vs1_vfirst, logic'(m == 0),
                   vl, '0, sparse_vreg(), rand_vreg(), rand_vreg(), rand_vreg());
        end
      end
    end
    finish_test("scalar");

    for (int n = 0; n < 6; n++) begin
      case (n)
        0: send_random(opmvv, funct6_vmand, '0, 1'b0);
        1: send_random(opmvv, funct6_vmxnor, '0, 1'b0);
        2: send_random(opmvv, funct6_vmorn, '0, 1'b0);
        3: send_random(opmvv, 6'h00, '0, 1'b1);
        4: send_random(funct3_t'(0), funct6_vmand, '0, 1'b1);
        default: send_random(opmvv, funct6_vmunary0, 5'h11, 1'b1);
      endcase
      send_random(opmvv, (n % 2 == 0) ? funct6_vmxor : funct6_vwxunary0, vs1_vfirst, 1'b1);
    end
    finish_test("unsupported");

    // vcpop and logical ops interleaved under rob stalls
    stall_mode = 1'b1;
    for (int n = 0; n < 20; n++) begin
      if (n % 2 == 0) begin
        send_random(opmvv, funct6_vwxunary0, vs1_vcpop, logic'($urandom_range(0, 1)));
      end else begin
        send_random(opmvv, funct6_t'(int'(funct6_vmandn) + $urandom_range(0, 7)), '0, 1'b1);
      end
    end
    finish_test("backpressure");
    stall_mode = 1'b0;

    for (int t = 0; t < rob_entries; t++) begin
      assert (issued_cnt[t] == done_cnt[t]) else begin
        $display("tag %0d still waits for %0d results", t, issued_cnt[t] - done_cnt[t]);
        stim_errors++;
      end
    end
    $display("tests %0d, results checked %0d, errors %0d", tests_run, checks,
             stim_errors + mon_errors);
    if (stim_errors + mon_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+.
rvv_mask_dim_pkg.sv
rvv_mask_op_pkg.sv
mask_uop_if.sv
mask_result_if.sv
rvv_mask_issue.sv
rvv_mask_logic_unit.sv
rvv_mask_scan_unit.sv
rvv_mask_result_arb.sv
rvv_mask_top.sv
tb_rvv_mask.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mask unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvv_mask -f sim.f -o tb_rvv_mask

./obj_dir/tb_rvv_mask | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
